// ==== include/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Datapath and reorder-buffer sizing
`define ISSUE_XLEN       32
`define ISSUE_ROB_TAG_W  3                        // Tag 0 reserved for "value valid"
`define ISSUE_ROB_DEPTH  (1 << `ISSUE_ROB_TAG_W)
`define ISSUE_NUM_REGS   32

// Major opcodes of the kept instruction classes
`define ISSUE_OPC_LUI    7'b0110111
`define ISSUE_OPC_AUIPC  7'b0010111
`define ISSUE_OPC_OP_IMM 7'b0010011
`define ISSUE_OPC_OP     7'b0110011
`define ISSUE_OPC_LOAD   7'b0000011

`endif

// ==== design/issue_pkg.sv ====
`default_nettype none

`include "issue_cfg.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]      word_t;
    typedef logic [`ISSUE_ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [4:0]                  reg_idx_t;

    // {funct7[5], funct3}
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  mem_op_t;     // Load width and sign, straight from funct3
    typedef logic [11:0] ld_offset_t;

    // Instruction classes the issue stage knows about
    typedef enum logic [2:0] {
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_OP_IMM,
        CLASS_OP,
        CLASS_LOAD,
        CLASS_NONE      // Anything else, dropped at issue
    } instr_class_t;

    // No producer pending, operand value is valid
    localparam rob_tag_t TAG_NONE = '0;

endpackage

`default_nettype wire

// ==== design/instr_field_decode.sv ====
`default_nettype none

`include "issue_cfg.svh"

module instr_field_decode (
    input  issue_pkg::word_t        inst,
    output issue_pkg::instr_class_t inst_class,
    output issue_pkg::reg_idx_t     rd,
    output issue_pkg::reg_idx_t     rs1,
    output issue_pkg::reg_idx_t     rs2,
    output issue_pkg::alu_op_t      alu_op,
    output issue_pkg::word_t        imm_value,
    output issue_pkg::ld_offset_t   load_offset,
    output logic                    uses_rs2
);
    import issue_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift;
    word_t      imm_i;
    word_t      imm_u;
    word_t      shamt;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);    // SLLI, SRLI, SRAI

    assign imm_i = {{(`ISSUE_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], {(`ISSUE_XLEN-20){1'b0}}};
    assign shamt = {{(`ISSUE_XLEN-5){1'b0}}, inst[24:20]};

    assign load_offset = inst[31:20];
    assign uses_rs2    = (inst_class == CLASS_OP);   // Only R-type reads a second register

    always_comb begin
        case (opcode)
            `ISSUE_OPC_LUI:    inst_class = CLASS_LUI;
            `ISSUE_OPC_AUIPC:  inst_class = CLASS_AUIPC;
            `ISSUE_OPC_OP_IMM: inst_class = CLASS_OP_IMM;
            `ISSUE_OPC_OP:     inst_class = CLASS_OP;
            `ISSUE_OPC_LOAD:   inst_class = CLASS_LOAD;
            default:           inst_class = CLASS_NONE;
        endcase
    end

    // Second operand and ALU op per class
    always_comb begin
        alu_op    = '0;     // AUIPC adds, op 0
        imm_value = '0;
        case (inst_class)
            CLASS_LUI, CLASS_AUIPC: imm_value = imm_u;
            CLASS_OP_IMM: begin
                if (is_shift) begin
                    alu_op    = {inst[30], funct3};   // Bit 30 picks SRAI over SRLI
                    imm_value = shamt;
                end else begin
                    alu_op    = {1'b0, funct3};
                    imm_value = imm_i;
                end
            end
            CLASS_OP: alu_op = {inst[30], funct3};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/operand_lookup.sv ====
`default_nettype none

`include "issue_cfg.svh"

module operand_lookup (
    input  issue_pkg::reg_idx_t src,
    input  issue_pkg::rob_tag_t regfile_tag [`ISSUE_NUM_REGS],
    input  issue_pkg::word_t    regfile_data [`ISSUE_NUM_REGS],
    input  issue_pkg::word_t    rob_values [`ISSUE_ROB_DEPTH],
    input  logic                rob_ready [`ISSUE_ROB_DEPTH],
    input  issue_pkg::rob_tag_t cdb_alu_tag,
    input  issue_pkg::word_t    cdb_alu_value,
    input  issue_pkg::rob_tag_t cdb_mem_tag,
    input  issue_pkg::word_t    cdb_mem_value,
    input  logic                last_rob_enabled,
    input  issue_pkg::reg_idx_t last_rob_dest,
    input  logic                last_value_ready,
    input  issue_pkg::word_t    last_rob_value,
    input  issue_pkg::rob_tag_t last_tag,
    output issue_pkg::word_t    value,
    output issue_pkg::rob_tag_t tag
);
    import issue_pkg::*;

    rob_tag_t table_tag;

    assign table_tag = regfile_tag[src];

    always_comb begin
        value = '0;
        tag   = table_tag;
        // Last issued instruction has not reached the tag table yet
        if (last_rob_enabled && (last_rob_dest == src)) begin
            if (last_value_ready) begin
                value = last_rob_value;     // LUI result known at issue
                tag   = TAG_NONE;
            end else begin
                tag = last_tag;
            end
        end else if (table_tag == TAG_NONE) begin
            value = regfile_data[src];
        end else if (cdb_alu_tag == table_tag) begin
            value = cdb_alu_value;
            tag   = TAG_NONE;
        end else if (cdb_mem_tag == table_tag) begin
            value = cdb_mem_value;
            tag   = TAG_NONE;
        end else if (rob_ready[table_tag]) begin
            value = rob_values[table_tag];  // Finished but not yet committed
            tag   = TAG_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_control.sv ====
`default_nettype none

module issue_control (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    inst_valid,
    input  issue_pkg::word_t        inst,
    input  issue_pkg::word_t        inst_pc,
    input  issue_pkg::rob_tag_t     rob_id,
    input  logic                    rob_full,
    input  logic                    alu_full,
    input  logic                    load_full,
    input  issue_pkg::instr_class_t inst_class,
    input  issue_pkg::reg_idx_t     rd,
    input  issue_pkg::alu_op_t      dec_alu_op,
    input  issue_pkg::word_t        imm_value,
    input  issue_pkg::ld_offset_t   dec_offset,
    input  logic                    uses_rs2,
    input  issue_pkg::word_t        rs1_value,
    input  issue_pkg::rob_tag_t     rs1_tag,
    input  issue_pkg::word_t        rs2_value,
    input  issue_pkg::rob_tag_t     rs2_tag,
    output issue_pkg::word_t        cur_inst,
    output issue_pkg::word_t        cur_pc,
    output logic                    fetch_redirect,
    output issue_pkg::word_t        fetch_pc,
    output logic                    rob_enabled,
    output logic                    rob_value_ready,
    output issue_pkg::word_t        rob_value,
    output issue_pkg::reg_idx_t     rob_dest,
    output logic                    regfile_enabled,
    output issue_pkg::reg_idx_t     regfile_reg,
    output issue_pkg::rob_tag_t     regfile_tag_out,
    output logic                    alu_enabled,
    output issue_pkg::alu_op_t      alu_op,
    output issue_pkg::word_t        alu_vj,
    output issue_pkg::word_t        alu_vk,
    output issue_pkg::rob_tag_t     alu_qj,
    output issue_pkg::rob_tag_t     alu_qk,
    output issue_pkg::rob_tag_t     alu_dest,
    output logic                    load_enabled,
    output issue_pkg::mem_op_t      load_op,
    output issue_pkg::word_t        load_vj,
    output issue_pkg::rob_tag_t     load_qj,
    output issue_pkg::rob_tag_t     load_dest,
    output issue_pkg::ld_offset_t   load_offset
);
    import issue_pkg::*;

    logic  retrying;
    word_t held_inst;
    word_t held_pc;
    logic  issue_req;
    logic  known;
    logic  needs_alu;
    logic  is_load;
    logic  stall;
    logic  stall_hit;
    logic  issue_go;

    // While retrying the decode sees the held instruction
    assign cur_inst = retrying ? held_inst : inst;
    assign cur_pc   = retrying ? held_pc : inst_pc;

    assign issue_req = retrying || inst_valid;     // Fetch strobe ignored during retry
    assign known     = (inst_class != CLASS_NONE);
    assign needs_alu = (inst_class == CLASS_AUIPC) || (inst_class == CLASS_OP_IMM) ||
                       (inst_class == CLASS_OP);
    assign is_load   = (inst_class == CLASS_LOAD);

    // LUI only needs a ROB slot
    assign stall     = rob_full || (needs_alu && alu_full) || (is_load && load_full);
    assign stall_hit = issue_req && known && stall;
    assign issue_go  = issue_req && known && !stall;

    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            retrying        <= 1'b0;
            fetch_redirect  <= 1'b0;
            rob_enabled     <= 1'b0;
            regfile_enabled <= 1'b0;
            alu_enabled     <= 1'b0;
            load_enabled    <= 1'b0;
        end else begin
            retrying        <= stall_hit;   // Cleared by the first edge that issues
            fetch_redirect  <= stall_hit;   // Refetch from the instruction after the held one
            rob_enabled     <= issue_go;
            regfile_enabled <= issue_go;
            alu_enabled     <= issue_go && needs_alu;
            load_enabled    <= issue_go && is_load;
        end
    end

    // Payloads only mean something alongside their enables
    always_ff @(posedge clk_in) begin
        if (issue_req) begin
            held_inst <= cur_inst;
            held_pc   <= cur_pc;
            fetch_pc  <= cur_pc + word_t'(4);

            rob_value_ready <= (inst_class == CLASS_LUI);
            rob_value       <= (inst_class == CLASS_LUI) ? imm_value : '0;
            rob_dest        <= rd;
            regfile_reg     <= rd;
            regfile_tag_out <= rob_id;

            alu_op   <= dec_alu_op;
            alu_vj   <= (inst_class == CLASS_AUIPC) ? cur_pc : rs1_value;
            alu_qj   <= (inst_class == CLASS_AUIPC) ? TAG_NONE : rs1_tag;
            alu_vk   <= uses_rs2 ? rs2_value : imm_value;    // Immediate forms carry no tag
            alu_qk   <= uses_rs2 ? rs2_tag : TAG_NONE;
            alu_dest <= rob_id;

            load_op     <= cur_inst[14:12];
            load_vj     <= rs1_value;   // Base address
            load_qj     <= rs1_tag;
            load_dest   <= rob_id;
            load_offset <= dec_offset;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_unit_top.sv ====
`default_nettype none

`include "issue_cfg.svh"

module issue_unit_top (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  inst_valid,
    input  issue_pkg::word_t      inst,
    input  issue_pkg::word_t      inst_pc,
    input  issue_pkg::rob_tag_t   rob_id,
    input  logic                  rob_full,
    input  logic                  alu_full,
    input  logic                  load_full,
    input  issue_pkg::rob_tag_t   regfile_tag [`ISSUE_NUM_REGS],
    input  issue_pkg::word_t      regfile_data [`ISSUE_NUM_REGS],
    input  issue_pkg::word_t      rob_values [`ISSUE_ROB_DEPTH],
    input  logic                  rob_ready [`ISSUE_ROB_DEPTH],
    input  issue_pkg::rob_tag_t   cdb_alu_tag,
    input  issue_pkg::word_t      cdb_alu_value,
    input  issue_pkg::rob_tag_t   cdb_mem_tag,
    input  issue_pkg::word_t      cdb_mem_value,
    output logic                  fetch_redirect,
    output issue_pkg::word_t      fetch_pc,
    output logic                  rob_enabled,
    output logic                  rob_value_ready,
    output issue_pkg::word_t      rob_value,
    output issue_pkg::reg_idx_t   rob_dest,
    output logic                  regfile_enabled,
    output issue_pkg::reg_idx_t   regfile_reg,
    output issue_pkg::rob_tag_t   regfile_tag_out,
    output logic                  alu_enabled,
    output issue_pkg::alu_op_t    alu_op,
    output issue_pkg::word_t      alu_vj,
    output issue_pkg::word_t      alu_vk,
    output issue_pkg::rob_tag_t   alu_qj,
    output issue_pkg::rob_tag_t   alu_qk,
    output issue_pkg::rob_tag_t   alu_dest,
    output logic                  load_enabled,
    output issue_pkg::mem_op_t    load_op,
    output issue_pkg::word_t      load_vj,
    output issue_pkg::rob_tag_t   load_qj,
    output issue_pkg::rob_tag_t   load_dest,
    output issue_pkg::ld_offset_t load_offset
);

    issue_pkg::word_t        cur_inst;
    issue_pkg::word_t        cur_pc;
    issue_pkg::instr_class_t inst_class;
    issue_pkg::reg_idx_t     rd;
    issue_pkg::reg_idx_t     rs1;
    issue_pkg::reg_idx_t     rs2;
    issue_pkg::alu_op_t      dec_alu_op;
    issue_pkg::word_t        imm_value;
    issue_pkg::ld_offset_t   dec_offset;
    logic                    uses_rs2;
    issue_pkg::word_t        rs1_value;
    issue_pkg::rob_tag_t     rs1_tag;
    issue_pkg::word_t        rs2_value;
    issue_pkg::rob_tag_t     rs2_tag;

    instr_field_decode u_decode (
        .inst        (cur_inst),
        .inst_class  (inst_class),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .alu_op      (dec_alu_op),
        .imm_value   (imm_value),
        .load_offset (dec_offset),
        .uses_rs2    (uses_rs2)
    );

    // Same lookup for both sources, bypassing from the registered issue outputs
    operand_lookup u_lookup_rs1 (
        .src              (rs1),
        .regfile_tag      (regfile_tag),
        .regfile_data     (regfile_data),
        .rob_values       (rob_values),
        .rob_ready        (rob_ready),
        .cdb_alu_tag      (cdb_alu_tag),
        .cdb_alu_value    (cdb_alu_value),
        .cdb_mem_tag      (cdb_mem_tag),
        .cdb_mem_value    (cdb_mem_value),
        .last_rob_enabled (rob_enabled),
        .last_rob_dest    (rob_dest),
        .last_value_ready (rob_value_ready),
        .last_rob_value   (rob_value),
        .last_tag         (regfile_tag_out),
        .value            (rs1_value),
        .tag              (rs1_tag)
    );

    operand_lookup u_lookup_rs2 (
        .src              (rs2),
        .regfile_tag      (regfile_tag),
        .regfile_data     (regfile_data),
        .rob_values       (rob_values),
        .rob_ready        (rob_ready),
        .cdb_alu_tag      (cdb_alu_tag),
        .cdb_alu_value    (cdb_alu_value),
        .cdb_mem_tag      (cdb_mem_tag),
        .cdb_mem_value    (cdb_mem_value),
        .last_rob_enabled (rob_enabled),
        .last_rob_dest    (rob_dest),
        .last_value_ready (rob_value_ready),
        .last_rob_value   (rob_value),
        .last_tag         (regfile_tag_out),
        .value            (rs2_value),
        .tag              (rs2_tag)
    );

    // Port names match the top and the wires above
    issue_control u_control (.*);

endmodule

`default_nettype wire

// ==== verif/issue_unit_assert.sv ====
`default_nettype none

module issue_unit_assert (
    input logic clk_in,
    input logic reset,
    input logic fetch_redirect,
    input logic rob_enabled,
    input logic regfile_enabled,
    input logic alu_enabled,
    input logic load_enabled
);

    int fail_count = 0;

    // One station per issued instruction
    one_station: assert property (@(posedge clk_in) disable iff (reset)
        !(alu_enabled && load_enabled))
        else begin
            fail_count++;
            $error("ALU and load stations enabled in the same cycle");
        end

    station_needs_rob: assert property (@(posedge clk_in) disable iff (reset)
        (alu_enabled || load_enabled || regfile_enabled) |-> rob_enabled)
        else begin
            fail_count++;
            $error("Station or register file enabled without a ROB entry");
        end

    redirect_alone: assert property (@(posedge clk_in) disable iff (reset)
        fetch_redirect |-> !rob_enabled)
        else begin
            fail_count++;
            $error("Fetch redirect together with an issue");
        end

    // Everything quiet one cycle after a reset edge
    quiet_after_reset: assert property (@(posedge clk_in)
        reset |=> !(fetch_redirect || rob_enabled || regfile_enabled ||
                    alu_enabled || load_enabled))
        else begin
            fail_count++;
            $error("Output enable high in the cycle after reset");
        end

endmodule

bind issue_control issue_unit_assert u_assert (.*);

`default_nettype wire

// ==== verif/issue_checker.sv ====
`default_nettype none

`include "issue_cfg.svh"

module issue_checker (
    input  logic                  clk_in,
    input  logic                  check_en,
    input  logic [127:0]          test_name,
    input  logic [4:0]            exp_en,
    input  issue_pkg::alu_op_t    exp_op,
    input  issue_pkg::word_t      exp_vj,
    input  issue_pkg::word_t      exp_vk,
    input  issue_pkg::rob_tag_t   exp_qj,
    input  issue_pkg::rob_tag_t   exp_qk,
    input  issue_pkg::rob_tag_t   exp_dest,
    input  issue_pkg::reg_idx_t   exp_rd,
    input  logic                  fetch_redirect,
    input  issue_pkg::word_t      fetch_pc,
    input  logic                  rob_enabled,
    input  logic                  rob_value_ready,
    input  issue_pkg::word_t      rob_value,
    input  issue_pkg::reg_idx_t   rob_dest,
    input  logic                  regfile_enabled,
    input  issue_pkg::reg_idx_t   regfile_reg,
    input  issue_pkg::rob_tag_t   regfile_tag_out,
    input  logic                  alu_enabled,
    input  issue_pkg::alu_op_t    alu_op,
    input  issue_pkg::word_t      alu_vj,
    input  issue_pkg::word_t      alu_vk,
    input  issue_pkg::rob_tag_t   alu_qj,
    input  issue_pkg::rob_tag_t   alu_qk,
    input  issue_pkg::rob_tag_t   alu_dest,
    input  logic                  load_enabled,
    input  issue_pkg::mem_op_t    load_op,
    input  issue_pkg::word_t      load_vj,
    input  issue_pkg::rob_tag_t   load_qj,
    input  issue_pkg::rob_tag_t   load_dest,
    input  issue_pkg::ld_offset_t load_offset,
    output int                    test_count,
    output int                    error_count
);
    import issue_pkg::*;

    logic         pend_valid = 1'b0;
    logic [127:0] pend_name;
    logic [4:0]   pend_en;
    alu_op_t      pend_op;
    word_t        pend_vj;
    word_t        pend_vk;
    rob_tag_t     pend_qj;
    rob_tag_t     pend_qk;
    rob_tag_t     pend_dest;
    reg_idx_t     pend_rd;
    logic         bad;
    logic         rob_only;
    string        bad_field;
    word_t        bad_exp;
    word_t        bad_act;

    initial begin
        test_count  = 0;
        error_count = 0;
    end

    // Keeps only the first mismatch of a test
    task automatic compare_field(input string field, input word_t exp, input word_t act);
        if ((act !== exp) && !bad) begin
            bad       = 1'b1;
            bad_field = field;
            bad_exp   = exp;
            bad_act   = act;
        end
    endtask

    // Expectations of the strobe sampled at this edge
    always @(posedge clk_in) begin
        pend_valid <= check_en;
        pend_name  <= test_name;
        pend_en    <= exp_en;
        pend_op    <= exp_op;
        pend_vj    <= exp_vj;
        pend_vk    <= exp_vk;
        pend_qj    <= exp_qj;
        pend_qk    <= exp_qk;
        pend_dest  <= exp_dest;
        pend_rd    <= exp_rd;
    end

    // Registered outputs are settled at the falling edge
    always @(negedge clk_in) begin
        if (pend_valid) begin
            bad      = 1'b0;
            rob_only = !(pend_en[1] || pend_en[0]);   // LUI, value known at issue
            compare_field("enables", word_t'(pend_en), word_t'({fetch_redirect, rob_enabled,
                          regfile_enabled, alu_enabled, load_enabled}));
            if (pend_en[4])
                compare_field("fetch_pc", pend_vj, fetch_pc);
            if (pend_en[3]) begin
                compare_field("rob_dest", word_t'(pend_rd), word_t'(rob_dest));
                compare_field("regfile_reg", word_t'(pend_rd), word_t'(regfile_reg));
                compare_field("regfile_tag", word_t'(pend_dest), word_t'(regfile_tag_out));
                compare_field("value_ready", word_t'(rob_only), word_t'(rob_value_ready));
                if (rob_only)
                    compare_field("rob_value", pend_vk, rob_value);
            end
            if (pend_en[1]) begin
                compare_field("alu_op", word_t'(pend_op), word_t'(alu_op));
                compare_field("alu_vj", pend_vj, alu_vj);
                compare_field("alu_vk", pend_vk, alu_vk);
                compare_field("alu_qj", word_t'(pend_qj), word_t'(alu_qj));
                compare_field("alu_qk", word_t'(pend_qk), word_t'(alu_qk));
                compare_field("alu_dest", word_t'(pend_dest), word_t'(alu_dest));
            end
            if (pend_en[0]) begin
                compare_field("load_op", word_t'(pend_op), word_t'(load_op));
                compare_field("load_vj", pend_vj, load_vj);
                compare_field("load_offset", word_t'(pend_vk[11:0]), word_t'(load_offset));
                compare_field("load_qj", word_t'(pend_qj), word_t'(load_qj));
                compare_field("load_dest", word_t'(pend_dest), word_t'(load_dest));
            end
            test_count++;
            if (bad) begin
                error_count++;
                $display("FAILED %0s %s: expected %h, actual %h",
                         pend_name, bad_field, bad_exp, bad_act);
            end else begin
                $display("ok     %0s", pend_name);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/issue_unit_tb.sv ====
`default_nettype none

`include "issue_cfg.svh"

module issue_unit_tb;
    import issue_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_TEST = 20;
    localparam int GOLDEN_COLUMNS  = 22;

    logic         clk_in = 1'b0;
    logic         reset;
    logic         flush;
    logic         inst_valid;
    word_t        inst;
    word_t        inst_pc;
    rob_tag_t     rob_id;
    logic         rob_full;
    logic         alu_full;
    logic         load_full;
    rob_tag_t     regfile_tag [`ISSUE_NUM_REGS];
    word_t        regfile_data [`ISSUE_NUM_REGS];
    word_t        rob_values [`ISSUE_ROB_DEPTH];
    logic         rob_ready [`ISSUE_ROB_DEPTH];
    rob_tag_t     cdb_alu_tag;
    word_t        cdb_alu_value;
    rob_tag_t     cdb_mem_tag;
    word_t        cdb_mem_value;

    logic         fetch_redirect;
    word_t        fetch_pc;
    logic         rob_enabled;
    logic         rob_value_ready;
    word_t        rob_value;
    reg_idx_t     rob_dest;
    logic         regfile_enabled;
    reg_idx_t     regfile_reg;
    rob_tag_t     regfile_tag_out;
    logic         alu_enabled;
    alu_op_t      alu_op;
    word_t        alu_vj;
    word_t        alu_vk;
    rob_tag_t     alu_qj;
    rob_tag_t     alu_qk;
    rob_tag_t     alu_dest;
    logic         load_enabled;
    mem_op_t      load_op;
    word_t        load_vj;
    rob_tag_t     load_qj;
    rob_tag_t     load_dest;
    ld_offset_t   load_offset;

    // Expectations handed to the checker with each strobe
    logic         check_en;
    logic [127:0] test_name;
    logic [4:0]   exp_en;
    alu_op_t      exp_op;
    word_t        exp_vj;
    word_t        exp_vk;
    rob_tag_t     exp_qj;
    rob_tag_t     exp_qk;
    rob_tag_t     exp_dest;
    reg_idx_t     exp_rd;

    string        lines[$];
    int           num_tests;
    logic         loaded = 1'b0;
    int           test_count;
    int           error_count;
    int           parse_errors = 0;
    int           assert_errors;

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    issue_unit_top dut (.*);

    issue_checker u_checker (.*);

    task automatic read_golden();
        int    fd;
        string line;
        fd = $fopen("verif/issue_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/issue_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 1) && (line.getc(0) != "#"))    // Skip blanks and notes
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    task automatic apply_test(input int idx, input string line);
        logic [127:0] name;
        logic [31:0]  inst_h, pc_h, alu_val, mem_val, en, op, vj, vk;
        int           valid_i, flush_i, rob_id_i, rf, af, lf, ovr_reg, ovr_tag;
        int           alu_tag_i, mem_tag_i, ready_idx, qj, qk, count;
        count = $sscanf(line, "%s %d %d %h %h %d %d %d %d %d %d %d %h %d %h %d %h %h %h %h %d %d",
                        name, valid_i, flush_i, inst_h, pc_h, rob_id_i, rf, af, lf,
                        ovr_reg, ovr_tag, alu_tag_i, alu_val, mem_tag_i, mem_val, ready_idx,
                        en, op, vj, vk, qj, qk);
        if (count != GOLDEN_COLUMNS) begin
            $display("Golden line %0d has %0d columns instead of %0d",
                     idx, count, GOLDEN_COLUMNS);
            parse_errors++;
            inst_valid = 1'b0;
            flush      = 1'b0;
            check_en   = 1'b0;
            return;
        end
        inst_valid = (valid_i != 0);
        flush      = (flush_i != 0);
        // Without a strobe the fetch bus carries an unrelated NOP
        inst       = (valid_i != 0) ? inst_h : 32'h0000_0013;
        inst_pc    = (valid_i != 0) ? pc_h : '0;
        rob_id     = rob_tag_t'(rob_id_i);
        rob_full   = (rf != 0);
        alu_full   = (af != 0);
        load_full  = (lf != 0);
        for (int i = 0; i < `ISSUE_NUM_REGS; i++)
            regfile_tag[i] = '0;
        regfile_tag[ovr_reg] = rob_tag_t'(ovr_tag);   // One pending producer per test
        for (int i = 0; i < `ISSUE_ROB_DEPTH; i++)
            rob_ready[i] = (i == ready_idx);
        cdb_alu_tag   = rob_tag_t'(alu_tag_i);
        cdb_alu_value = alu_val;
        cdb_mem_tag   = rob_tag_t'(mem_tag_i);
        cdb_mem_value = mem_val;

        test_name = name;
        exp_en    = en[4:0];
        exp_op    = op[3:0];
        exp_vj    = vj;
        exp_vk    = vk;
        exp_qj    = rob_tag_t'(qj);
        exp_qk    = rob_tag_t'(qk);
        exp_dest  = rob_tag_t'(rob_id_i);
        exp_rd    = inst_h[11:7];   // rd field of the issued instruction
        check_en  = 1'b1;
    endtask

    initial begin
        reset         = 1'b1;
        flush         = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        inst_pc       = '0;
        rob_id        = '0;
        rob_full      = 1'b0;
        alu_full      = 1'b0;
        load_full     = 1'b0;
        cdb_alu_tag   = '0;
        cdb_alu_value = '0;
        cdb_mem_tag   = '0;
        cdb_mem_value = '0;
        check_en      = 1'b0;
        test_name     = '0;
        exp_en        = '0;
        exp_op        = '0;
        exp_vj        = '0;
        exp_vk        = '0;
        exp_qj        = '0;
        exp_qk        = '0;
        exp_dest      = '0;
        exp_rd        = '0;
        for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
            regfile_tag[i]  = '0;
            regfile_data[i] = word_t'(i) * word_t'(16'h0101);
        end
        for (int i = 0; i < `ISSUE_ROB_DEPTH; i++) begin
            rob_values[i] = 32'h7000_0000 + word_t'(i) * 32'h0001_0001;
            rob_ready[i]  = 1'b0;
        end

        read_golden();
        num_tests = lines.size();
        loaded    = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;

        foreach (lines[i]) begin
            @(negedge clk_in);
            apply_test(i, lines[i]);
        end
        @(negedge clk_in);
        inst_valid = 1'b0;
        flush      = 1'b0;
        check_en   = 1'b0;
        @(posedge clk_in);   // Checker has judged the last test

        assert_errors = dut.u_control.u_assert.fail_count;
        $display("Summary: %0d/%0d checked, %0d failed, %0d assertion failures, %0d bad lines",
                 test_count, num_tests, error_count, assert_errors, parse_errors);
        if ((num_tests > 0) && (test_count == num_tests) && (error_count == 0) &&
            (assert_errors == 0) && (parse_errors == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (loaded);
        #((num_tests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
design/issue_pkg.sv
design/instr_field_decode.sv
design/operand_lookup.sv
design/issue_control.sv
design/issue_unit_top.sv
verif/issue_unit_assert.sv
verif/issue_checker.sv
verif/issue_unit_tb.sv

// ==== Bender.yml ====
package:
  name: issue_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/issue_pkg.sv
      - design/instr_field_decode.sv
      - design/operand_lookup.sv
      - design/issue_control.sv
      - design/issue_unit_top.sv
      - target: test
        files:
          - verif/issue_unit_assert.sv
          - verif/issue_checker.sv
          - verif/issue_unit_tb.sv

// ==== verif/issue_golden.txt ====
# name valid flush inst pc rob_id rob/alu/load_full reg tag cdb_alu(tag val) cdb_mem(tag val) ready
# expected en{redirect,rob,regfile,alu,load} op vj vk qj qk; redirect vj=fetch_pc; vk=offset or LUI value
add_regs 1 0 002081b3 0 1 0 0 0 0 0 0 0 0 0 0 0e 0 101 202 0 0
sub_regs 1 0 40628233 0 2 0 0 0 0 0 0 0 0 0 0 0e 8 505 606 0 0
addi_neg 1 0 ffb08393 0 3 0 0 0 0 0 0 0 0 0 0 0e 0 101 fffffffb 0 0
srai_bit30 1 0 40315413 0 4 0 0 0 0 0 0 0 0 0 0 0e d 202 3 0 0
lui_ready 1 0 123454b7 0 5 0 0 0 0 0 0 0 0 0 0 0c 0 0 12345000 0 0
auipc_pc 1 0 00001517 100 6 0 0 0 0 0 0 0 0 0 0 0e 0 100 1000 0 0
load_word 1 0 0081a583 0 7 0 0 0 0 0 0 0 0 0 0 0d 2 303 8 0 0
fwd_alu_cdb 1 0 00e68633 0 1 0 0 0 13 5 5 cafe0001 0 0 0 0e 0 cafe0001 e0e 0 0
fwd_mem_cdb 1 0 00178813 0 2 0 0 0 15 6 0 0 6 d00d0002 0 0e 0 d00d0002 1 0 0
fwd_rob_ready 1 0 00088913 0 3 0 0 0 17 4 0 0 0 0 4 0e 0 70040004 0 0 0
tag_pending 1 0 00298a13 0 4 0 0 0 19 5 0 0 0 0 0 0e 0 0 2 5 0
dep_tag 1 0 001a0ab3 0 5 0 0 0 0 0 0 0 0 0 0 0e 0 0 101 4 0
lui_prod 1 0 abcdeb37 0 6 0 0 0 0 0 0 0 0 0 0 0c 0 0 abcde000 0 0
dep_lui_value 1 0 016b0bb3 0 7 0 0 0 0 0 0 0 0 0 0 0e 0 abcde000 abcde000 0 0
alu_full_hold 1 0 00710c13 200 1 0 1 0 0 0 0 0 0 0 0 10 0 204 0 0 0
alu_full_retry 0 0 00710c13 200 1 0 1 0 0 0 0 0 0 0 0 10 0 204 0 0 0
alu_full_issue 0 0 00710c13 200 2 0 0 0 0 0 0 0 0 0 0 0e 0 202 7 0 0
rob_full_hold 1 0 00042cb7 300 3 1 0 0 0 0 0 0 0 0 0 10 0 304 0 0 0
rob_full_issue 0 0 00042cb7 300 3 0 0 0 0 0 0 0 0 0 0 0c 0 0 42000 0 0
load_full_hold 1 0 0040ad03 400 4 0 0 1 0 0 0 0 0 0 0 10 0 404 0 0 0
flush_retry 0 1 0040ad03 400 4 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0
after_flush 0 0 0040ad03 400 4 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0
bad_opcode 1 0 0000007f 500 5 1 1 1 0 0 0 0 0 0 0 00 0 0 0 0 0
or_regs 1 0 0062ee33 0 6 0 0 0 0 0 0 0 0 0 0 0e 6 505 606 0 0
